// File: common/udp_tx_settings.svh
`ifndef UDP_TX_SETTINGS_SVH
`define UDP_TX_SETTINGS_SVH

// byte FIFO capacity, a power of two
`define UDP_TX_FIFO_DEPTH 2048

// payload length width in bits
`define UDP_TX_LEN_W 11

// ethernet framing
`define UDP_TX_PREAMBLE_BYTES 7
`define UDP_TX_PREAMBLE_BYTE 8'h55
`define UDP_TX_SFD 8'hd5
`define UDP_TX_FCS_BYTES 4
`define UDP_TX_GAP_BYTES 12

`endif

// File: common/frame_pkg.sv
package frame_pkg;

    localparam int HDR_BYTES = 42;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // wire order, first byte on the wire sits in the msbs
    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_csum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   udp_src;
        udp_port_t   udp_dst;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } frame_hdr_fields_t;

    typedef union packed {
        frame_hdr_fields_t            fields;
        logic [0:HDR_BYTES-1][7:0]    octets;
    } frame_hdr_u;

endpackage

// File: common/tx_pkg.sv
package tx_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        DATA,
        FCS,
        GAP
    } tx_state_t;

    typedef logic [31:0] fcs_t;

    // 04c11db7 bit-reversed, for the lsb-first update
    localparam fcs_t CRC_POLY_REFL = 32'hedb8_8320;
    localparam fcs_t CRC_PRESET    = 32'hffff_ffff;

endpackage

// File: common/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if;
    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;

    modport source (
        output tdata, tvalid, tlast,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast,
        output tready
    );
endinterface

// File: logic/eth_header_gen.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module eth_header_gen (
    input  frame_pkg::mac_addr_t         fpga_mac_i,
    input  frame_pkg::mac_addr_t         host_mac_i,
    input  frame_pkg::ip_addr_t          fpga_ip_i,
    input  frame_pkg::ip_addr_t          host_ip_i,
    input  frame_pkg::udp_port_t         fpga_port_i,
    input  frame_pkg::udp_port_t         host_port_i,
    input  logic [`UDP_TX_LEN_W-1:0]     payload_bytes_i,
    output frame_pkg::frame_hdr_u        header_o
);
    import frame_pkg::*;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_TOS         = 8'h00;
    localparam logic [15:0] IP_IDENT       = 16'h0000;
    // don't fragment
    localparam logic [15:0] IP_FLAGS_FRAG  = 16'h4000;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    logic [15:0] ip_total_len;
    logic [15:0] udp_len;
    logic [19:0] csum_sum;
    logic [16:0] csum_fold1;
    logic [15:0] csum_fold2;

    assign ip_total_len = 16'(payload_bytes_i) + 16'd28;
    assign udp_len      = 16'(payload_bytes_i) + 16'd8;

    // ten ip header words, checksum word counted as zero
    assign csum_sum = 20'({IP_VER_IHL, IP_TOS}) + 20'(ip_total_len)
                    + 20'(IP_IDENT) + 20'(IP_FLAGS_FRAG)
                    + 20'({IP_TTL, IP_PROTO_UDP})
                    + 20'(fpga_ip_i[31:16]) + 20'(fpga_ip_i[15:0])
                    + 20'(host_ip_i[31:16]) + 20'(host_ip_i[15:0]);

    // end-around carry, the second fold cannot overflow again
    assign csum_fold1 = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
    assign csum_fold2 = csum_fold1[15:0] + 16'(csum_fold1[16]);

    always_comb begin
        header_o.fields.dst_mac    = host_mac_i;
        header_o.fields.src_mac    = fpga_mac_i;
        header_o.fields.ethertype  = ETHERTYPE_IPV4;
        header_o.fields.ver_ihl    = IP_VER_IHL;
        header_o.fields.tos        = IP_TOS;
        header_o.fields.total_len  = ip_total_len;
        header_o.fields.ident      = IP_IDENT;
        header_o.fields.flags_frag = IP_FLAGS_FRAG;
        header_o.fields.ttl        = IP_TTL;
        header_o.fields.protocol   = IP_PROTO_UDP;
        header_o.fields.hdr_csum   = ~csum_fold2;
        header_o.fields.src_ip     = fpga_ip_i;
        header_o.fields.dst_ip     = host_ip_i;
        header_o.fields.udp_src    = fpga_port_i;
        header_o.fields.udp_dst    = host_port_i;
        header_o.fields.udp_len    = udp_len;
        // udp checksum not computed
        header_o.fields.udp_csum   = 16'h0000;
    end

endmodule

// File: logic/byte_fifo.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module byte_fifo (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     push_i,
    input  logic [7:0]               wr_data_i,
    input  logic                     pop_i,
    output logic [7:0]               rd_data_o,
    output logic [`UDP_TX_LEN_W:0]   count_o
);
    localparam int DEPTH = `UDP_TX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = `UDP_TX_LEN_W + 1;

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && (count_q != CW'(DEPTH));
    assign do_pop  = pop_i && (count_q != '0);

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
        if (do_pop) begin
            rd_data_o <= mem[rd_ptr_q];
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign count_o = count_q;

endmodule

// File: logic/crc32_gmii.sv
`timescale 1ns/1ps

module crc32_gmii (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         clear_i,
    input  logic         en_i,
    input  logic [7:0]   data_i,
    output tx_pkg::fcs_t fcs_o
);
    import tx_pkg::*;

    fcs_t crc_q;

    // one byte, lsb first
    function automatic fcs_t crc_byte(fcs_t crc, logic [7:0] data);
        fcs_t r;
        r = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY_REFL) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= CRC_PRESET;
        end else if (en_i) begin
            crc_q <= crc_byte(crc_q, data_i);
        end
    end

    assign fcs_o = ~crc_q;

endmodule

// File: packet_gen/frame_admit.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module frame_admit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    byte_stream_if.sink               s,
    input  logic [`UDP_TX_LEN_W-1:0]  payload_bytes_i,
    input  logic [`UDP_TX_LEN_W:0]    fifo_count_i,
    output logic                      push_o,
    output logic [7:0]                push_data_o
);
    localparam int CW = `UDP_TX_LEN_W + 1;

    logic          in_pkt_q;
    logic          pkt_start;
    logic          has_space;
    logic          handshake;
    logic [CW-1:0] room_limit;

    // a whole packet must fit before its first byte is taken
    assign room_limit = CW'(`UDP_TX_FIFO_DEPTH) - {1'b0, payload_bytes_i};
    assign has_space  = fifo_count_i < room_limit;
    assign pkt_start  = !in_pkt_q;

    // once started, the rest of the packet is never held back
    assign s.tready  = (pkt_start && has_space) || in_pkt_q;
    assign handshake = s.tvalid && s.tready;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            in_pkt_q <= 1'b0;
        end else if (handshake) begin
            in_pkt_q <= !s.tlast;
        end
    end

    assign push_o      = handshake;
    assign push_data_o = s.tdata;

endmodule

// File: packet_gen/packet_gen.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module packet_gen (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  frame_pkg::frame_hdr_u     header_i,
    input  logic [`UDP_TX_LEN_W-1:0]  payload_bytes_i,
    input  logic [`UDP_TX_LEN_W:0]    fifo_count_i,
    input  logic [7:0]                fifo_data_i,
    input  tx_pkg::fcs_t              fcs_i,
    output logic                      pop_o,
    output logic                      crc_clear_o,
    output logic                      crc_en_o,
    output logic [7:0]                crc_data_o,
    output logic                      tx_en_o,
    output logic [7:0]                tx_d_o
);
    import frame_pkg::*;
    import tx_pkg::*;

    localparam int LEN_W  = `UDP_TX_LEN_W;
    localparam int HDR_IW = $clog2(HDR_BYTES);

    localparam logic [LEN_W-1:0] PRE_LAST = LEN_W'(`UDP_TX_PREAMBLE_BYTES - 1);
    localparam logic [LEN_W-1:0] HDR_LAST = LEN_W'(HDR_BYTES - 1);
    localparam logic [LEN_W-1:0] FCS_LAST = LEN_W'(`UDP_TX_FCS_BYTES - 1);
    localparam logic [LEN_W-1:0] GAP_LAST = LEN_W'(`UDP_TX_GAP_BYTES - 1);

    tx_state_t        state_q;
    tx_state_t        state_d;
    logic [LEN_W-1:0] cnt_q;
    logic [LEN_W-1:0] data_last;
    logic             last;
    frame_hdr_u       hdr_q;
    fcs_t             fcs_q;
    fcs_t             fcs_cur;
    logic             tx_valid;
    logic [7:0]       tx_byte;

    assign data_last = payload_bytes_i - 1'b1;

    // final cycle of the current state
    always_comb begin
        case (state_q)
            IDLE:     last = fifo_count_i >= {1'b0, payload_bytes_i};
            PREAMBLE: last = cnt_q == PRE_LAST;
            SFD:      last = 1'b1;
            HEADER:   last = cnt_q == HDR_LAST;
            DATA:     last = cnt_q == data_last;
            FCS:      last = cnt_q == FCS_LAST;
            GAP:      last = cnt_q == GAP_LAST;
            default:  last = 1'b1;
        endcase
    end

    always_comb begin
        state_d = state_q;
        if (last) begin
            case (state_q)
                IDLE:     state_d = PREAMBLE;
                PREAMBLE: state_d = SFD;
                SFD:      state_d = HEADER;
                HEADER:   state_d = DATA;
                DATA:     state_d = FCS;
                FCS:      state_d = GAP;
                default:  state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (last) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // crc is final on the first fcs cycle, later bytes come from the shifter
    assign fcs_cur = (cnt_q == '0) ? fcs_i : fcs_q;

    always_comb begin
        tx_valid = 1'b1;
        tx_byte  = 8'h00;
        case (state_q)
            PREAMBLE: tx_byte = `UDP_TX_PREAMBLE_BYTE;
            SFD:      tx_byte = `UDP_TX_SFD;
            HEADER:   tx_byte = hdr_q.octets[cnt_q[HDR_IW-1:0]];
            DATA:     tx_byte = fifo_data_i;
            FCS:      tx_byte = fcs_cur[7:0];
            default:  tx_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            hdr_q <= header_i;
        end
        if (state_q == FCS) begin
            fcs_q <= fcs_cur >> 8;
        end
    end

    // pop one cycle ahead so each byte is on the fifo output in its DATA cycle
    assign pop_o = (state_q == HEADER && last) || (state_q == DATA && !last);

    assign crc_clear_o = state_q == IDLE;
    assign crc_en_o    = state_q == HEADER || state_q == DATA;
    assign crc_data_o  = tx_byte;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= tx_valid;
        end
        tx_d_o <= tx_byte;
    end

endmodule

// File: logic/udp_tx_top.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module udp_tx_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  frame_pkg::mac_addr_t      fpga_mac_i,
    input  frame_pkg::mac_addr_t      host_mac_i,
    input  frame_pkg::ip_addr_t       fpga_ip_i,
    input  frame_pkg::ip_addr_t       host_ip_i,
    input  frame_pkg::udp_port_t      fpga_port_i,
    input  frame_pkg::udp_port_t      host_port_i,
    input  logic [`UDP_TX_LEN_W-1:0]  payload_bytes_i,
    input  logic [7:0]                s_tdata_i,
    input  logic                      s_tvalid_i,
    input  logic                      s_tlast_i,
    output logic                      s_tready_o,
    output logic                      tx_en_o,
    output logic [7:0]                tx_d_o
);
    import frame_pkg::*;
    import tx_pkg::*;

    byte_stream_if s_bus ();

    logic                    push;
    logic [7:0]              push_data;
    logic                    pop;
    logic [7:0]              fifo_data;
    logic [`UDP_TX_LEN_W:0]  fifo_count;
    frame_hdr_u              header;
    logic                    crc_clear;
    logic                    crc_en;
    logic [7:0]              crc_data;
    fcs_t                    fcs;

    assign s_bus.tdata  = s_tdata_i;
    assign s_bus.tvalid = s_tvalid_i;
    assign s_bus.tlast  = s_tlast_i;
    assign s_tready_o   = s_bus.tready;

    frame_admit i_frame_admit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .s              (s_bus),
        .payload_bytes_i(payload_bytes_i),
        .fifo_count_i   (fifo_count),
        .push_o         (push),
        .push_data_o    (push_data)
    );

    byte_fifo i_byte_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .push_i   (push),
        .wr_data_i(push_data),
        .pop_i    (pop),
        .rd_data_o(fifo_data),
        .count_o  (fifo_count)
    );

    eth_header_gen i_eth_header_gen (
        .fpga_mac_i     (fpga_mac_i),
        .host_mac_i     (host_mac_i),
        .fpga_ip_i      (fpga_ip_i),
        .host_ip_i      (host_ip_i),
        .fpga_port_i    (fpga_port_i),
        .host_port_i    (host_port_i),
        .payload_bytes_i(payload_bytes_i),
        .header_o       (header)
    );

    packet_gen i_packet_gen (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .header_i       (header),
        .payload_bytes_i(payload_bytes_i),
        .fifo_count_i   (fifo_count),
        .fifo_data_i    (fifo_data),
        .fcs_i          (fcs),
        .pop_o          (pop),
        .crc_clear_o    (crc_clear),
        .crc_en_o       (crc_en),
        .crc_data_o     (crc_data),
        .tx_en_o        (tx_en_o),
        .tx_d_o         (tx_d_o)
    );

    crc32_gmii i_crc32_gmii (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(crc_clear),
        .en_i   (crc_en),
        .data_i (crc_data),
        .fcs_o  (fcs)
    );

endmodule

// File: tb/udp_tx_chk.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module udp_tx_chk (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      tx_en_i,
    input logic [`UDP_TX_LEN_W-1:0]  payload_bytes_i,
    input logic [`UDP_TX_LEN_W:0]    fifo_count_i,
    input logic                      push_i
);
    localparam int CW       = `UDP_TX_LEN_W + 1;
    localparam int OVERHEAD = `UDP_TX_PREAMBLE_BYTES + 1 + 42 + `UDP_TX_FCS_BYTES;
    localparam int MIN_GAP  = `UDP_TX_GAP_BYTES + 1;

    logic [15:0] run_q;
    logic [15:0] gap_q;
    int          fail_count = 0;

    // length of the current high or low stretch of tx_en
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_q <= '0;
            gap_q <= 16'(MIN_GAP);
        end else if (tx_en_i) begin
            run_q <= run_q + 16'd1;
            gap_q <= '0;
        end else begin
            run_q <= '0;
            if (gap_q != 16'hffff) begin
                gap_q <= gap_q + 16'd1;
            end
        end
    end

    tx_en_reset_a: assert property (@(posedge clk_i) rst_i |=> !tx_en_i)
        else begin
            $error("tx_en high after a reset cycle");
            fail_count++;
        end

    frame_run_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(tx_en_i) |-> run_q == 16'(payload_bytes_i) + 16'(OVERHEAD))
        else begin
            $error("tx_en run of %0d cycles", run_q);
            fail_count++;
        end

    frame_gap_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(tx_en_i) |-> gap_q >= 16'(MIN_GAP))
        else begin
            $error("inter-frame gap of %0d cycles", gap_q);
            fail_count++;
        end

    full_push_a: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> fifo_count_i != CW'(`UDP_TX_FIFO_DEPTH))
        else begin
            $error("push into a full FIFO");
            fail_count++;
        end

endmodule

// framer and admission signals, seen from the top level
bind udp_tx_top udp_tx_chk udp_tx_chk_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .tx_en_i        (tx_en_o),
    .payload_bytes_i(payload_bytes_i),
    .fifo_count_i   (fifo_count),
    .push_i         (push)
);

// File: tb/udp_tx_tb.sv
`timescale 1ns/1ps
`include "udp_tx_settings.svh"

module udp_tx_tb;
    import frame_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'hdd8f_c0e5;
    localparam int          LEN_W        = `UDP_TX_LEN_W;
    localparam int          OVERHEAD     = `UDP_TX_PREAMBLE_BYTES + 1 + 42 + `UDP_TX_FCS_BYTES;
    localparam int          MIN_GAP      = `UDP_TX_GAP_BYTES + 1;
    localparam int          T2_LEN       = 46;
    localparam int          T3_LEN       = 100;
    localparam int          T3_PKTS      = 5;
    // about half the FIFO
    localparam int          T4_LEN       = 1024;
    localparam int          T4_PKTS      = 3;
    localparam int          T5_MAX       = 300;
    localparam int          T5_PKTS      = 3;
    localparam int          RUN_CYCLES   = RESET_CYCLES + 20
                                         + (T2_LEN + OVERHEAD + 2 * MIN_GAP)
                                         + T3_PKTS * (T3_LEN + OVERHEAD + 2 * MIN_GAP)
                                         + T4_PKTS * (2 * T4_LEN + OVERHEAD + 2 * MIN_GAP)
                                         + T5_PKTS * (T5_MAX + OVERHEAD + 2 * MIN_GAP);
    localparam int          CYCLE_LIMIT  = 2 * RUN_CYCLES + 1000;

    logic             clk_i = 1'b0;
    logic             rst_i;
    mac_addr_t        fpga_mac;
    mac_addr_t        host_mac;
    ip_addr_t         fpga_ip;
    ip_addr_t         host_ip;
    udp_port_t        fpga_port;
    udp_port_t        host_port;
    logic [LEN_W-1:0] payload_bytes;
    logic [7:0]       s_tdata;
    logic             s_tvalid;
    logic             s_tlast;
    logic             s_tready;
    logic             tx_en;
    logic [7:0]       tx_d;

    logic [7:0] pay_q[$];
    logic [7:0] frm_q[$];
    logic [7:0] exp_q[$];
    int         exp_len_q[$];
    logic [7:0] got_q[$];
    logic       in_frame;
    int         idle_run;
    int         frames_seen = 0;
    int         errors = 0;
    int         test_errors;
    int         test_num = 0;
    int         passed = 0;
    int         failed = 0;
    int         stall_cycles;
    int         cycle_count = 0;

    udp_tx_top udp_tx_top_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fpga_mac_i     (fpga_mac),
        .host_mac_i     (host_mac),
        .fpga_ip_i      (fpga_ip),
        .host_ip_i      (host_ip),
        .fpga_port_i    (fpga_port),
        .host_port_i    (host_port),
        .payload_bytes_i(payload_bytes),
        .s_tdata_i      (s_tdata),
        .s_tvalid_i     (s_tvalid),
        .s_tlast_i      (s_tlast),
        .s_tready_o     (s_tready),
        .tx_en_o        (tx_en),
        .tx_d_o         (tx_d)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ones'-complement sum of the ten ip header words, checksum word as zero
    function automatic logic [15:0] ip_checksum(logic [15:0] total_len);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(total_len) + 32'h0000 + 32'h4000 + 32'h4011;
        sum = sum + 32'(fpga_ip[31:16]) + 32'(fpga_ip[15:0]);
        sum = sum + 32'(host_ip[31:16]) + 32'(host_ip[15:0]);
        while (sum > 32'h0000_ffff) begin
            sum = (sum & 32'h0000_ffff) + (sum >> 16);
        end
        return ~sum[15:0];
    endfunction

    // ethernet crc-32, reflected 04c11db7, one bit at a time
    function automatic logic [31:0] crc_step(logic [31:0] crc, logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
        return c;
    endfunction

    function automatic string byte_region(int idx, int n);
        int h;
        h = idx - 8;
        if (idx < 7) begin
            return "preamble";
        end
        if (idx == 7) begin
            return "sfd";
        end
        if (h == 24 || h == 25) begin
            return "ip checksum";
        end
        if (h < 42) begin
            return "header";
        end
        if (h < 42 + n) begin
            return "payload";
        end
        return "fcs";
    endfunction

    task automatic put_bytes(input logic [47:0] value, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            frm_q.push_back(value[8*i +: 8]);
        end
    endtask

    // wire image of one frame around the payload in pay_q
    task automatic expect_frame();
        logic [31:0] crc;
        logic [15:0] total_len;
        int          n;
        n = pay_q.size();
        total_len = 16'(n + 28);
        frm_q.delete();
        put_bytes(host_mac, 6);
        put_bytes(fpga_mac, 6);
        put_bytes(48'h0800, 2);
        put_bytes(48'h4500, 2);
        put_bytes(48'(total_len), 2);
        // identification, then don't fragment
        put_bytes(48'h0000_4000, 4);
        put_bytes(48'h4011, 2);
        put_bytes(48'(ip_checksum(total_len)), 2);
        put_bytes(48'(fpga_ip), 4);
        put_bytes(48'(host_ip), 4);
        put_bytes(48'(fpga_port), 2);
        put_bytes(48'(host_port), 2);
        put_bytes(48'(n + 8), 2);
        put_bytes(48'h0000, 2);
        foreach (pay_q[i]) begin
            frm_q.push_back(pay_q[i]);
        end
        crc = 32'hffff_ffff;
        foreach (frm_q[i]) begin
            crc = crc_step(crc, frm_q[i]);
        end
        crc = ~crc;
        for (int i = 0; i < `UDP_TX_PREAMBLE_BYTES; i++) begin
            exp_q.push_back(8'h55);
        end
        exp_q.push_back(8'hd5);
        foreach (frm_q[i]) begin
            exp_q.push_back(frm_q[i]);
        end
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(crc[8*i +: 8]);
        end
        exp_len_q.push_back(OVERHEAD + n);
    endtask

    task automatic send_packet(input int n);
        int idx;
        pay_q.delete();
        for (int i = 0; i < n; i++) begin
            pay_q.push_back(8'($urandom));
        end
        expect_frame();
        idx = 0;
        while (idx < n) begin
            @(negedge clk_i);
            s_tvalid = 1'b1;
            s_tdata  = pay_q[idx];
            s_tlast  = (idx == n - 1);
            // tready does not depend on tvalid, so it is already settled
            if (s_tready) begin
                idx++;
            end else begin
                stall_cycles++;
                assert (idx == 0) else begin
                    $display("ERROR @ %0t: s_tready low inside a packet at byte %0d",
                             $time, idx);
                    errors++;
                end
            end
        end
    endtask

    task automatic stop_input();
        @(negedge clk_i);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // all frames out, then the gap and the return to idle
    task automatic wait_frames();
        while (exp_len_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (MIN_GAP) @(negedge clk_i);
    endtask

    task automatic check_frame();
        int         exp_len;
        int         bad;
        logic [7:0] exp_b;
        logic [7:0] bad_exp;
        logic [7:0] bad_got;
        bad = -1;
        assert (exp_len_q.size() > 0) else begin
            $display("a frame of %0d bytes came out with no packet sent", got_q.size());
            errors++;
        end
        if (exp_len_q.size() > 0) begin
            exp_len = exp_len_q.pop_front();
            assert (got_q.size() == exp_len) else begin
                $display("ERROR @ %0t: frame %0d has %0d bytes, expected %0d",
                         $time, frames_seen, got_q.size(), exp_len);
                errors++;
            end
            for (int i = 0; i < exp_len; i++) begin
                exp_b = exp_q.pop_front();
                if (bad < 0 && i < got_q.size() && got_q[i] != exp_b) begin
                    bad     = i;
                    bad_exp = exp_b;
                    bad_got = got_q[i];
                end
            end
            assert (bad < 0) else begin
                $display("ERROR @ %0t: frame %0d byte %0d (%s) is %h, expected %h",
                         $time, frames_seen, bad, byte_region(bad, exp_len - OVERHEAD),
                         bad_got, bad_exp);
                errors++;
            end
        end
        got_q.delete();
        frames_seen++;
    endtask

    always @(negedge clk_i) begin
        if (rst_i) begin
            in_frame = 1'b0;
            idle_run = MIN_GAP;
        end else if (tx_en) begin
            if (!in_frame && frames_seen > 0) begin
                assert (idle_run >= MIN_GAP) else begin
                    $display("ERROR @ %0t: %0d idle cycles before frame %0d",
                             $time, idle_run, frames_seen);
                    errors++;
                end
            end
            in_frame = 1'b1;
            got_q.push_back(tx_d);
        end else begin
            if (in_frame) begin
                check_frame();
                idle_run = 0;
            end
            in_frame = 1'b0;
            idle_run++;
        end
    end

    task automatic begin_test();
        test_num++;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            passed++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            failed++;
            $display("test %0d %s: FAIL with %0d errors", test_num, name, errors - test_errors);
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_i         = 1'b1;
        s_tvalid      = 1'b0;
        s_tdata       = 8'h00;
        s_tlast       = 1'b0;
        fpga_mac      = 48'h02_00_00_00_00_01;
        host_mac      = 48'h00_1b_21_3c_4d_5e;
        fpga_ip       = 32'hc0a8_0102;
        host_ip       = 32'hc0a8_0101;
        fpga_port     = 16'd4660;
        host_port     = 16'd5000;
        payload_bytes = LEN_W'(T2_LEN);
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        begin_test();
        repeat (20) begin
            @(negedge clk_i);
            assert (!tx_en && s_tready) else begin
                $display("ERROR @ %0t: after reset tx_en is %b, s_tready is %b",
                         $time, tx_en, s_tready);
                errors++;
            end
        end
        end_test("reset state");

        begin_test();
        send_packet(T2_LEN);
        stop_input();
        wait_frames();
        end_test("single packet");

        begin_test();
        payload_bytes = LEN_W'(T3_LEN);
        repeat (T3_PKTS) send_packet(T3_LEN);
        stop_input();
        wait_frames();
        end_test("back to back");

        begin_test();
        payload_bytes = LEN_W'(T4_LEN);
        stall_cycles  = 0;
        repeat (T4_PKTS) send_packet(T4_LEN);
        stop_input();
        wait_frames();
        assert (stall_cycles > 0) else begin
            $display("ERROR @ %0t: s_tready never dropped with a half-FIFO payload", $time);
            errors++;
        end
        end_test("back-pressure");

        begin_test();
        fpga_mac      = {16'($urandom), $urandom};
        host_mac      = {16'($urandom), $urandom};
        fpga_ip       = $urandom;
        host_ip       = $urandom;
        fpga_port     = 16'($urandom);
        host_port     = 16'($urandom);
        payload_bytes = LEN_W'($urandom_range(T5_MAX, 1));
        repeat (T5_PKTS) send_packet(int'(payload_bytes));
        stop_input();
        wait_frames();
        end_test("new configuration");

        $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 passed, failed, errors, udp_tx_top_i.udp_tx_chk_i.fail_count);
        if (failed == 0 && errors == 0 && udp_tx_top_i.udp_tx_chk_i.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: udp_tx.f
+incdir+common
common/frame_pkg.sv
common/tx_pkg.sv
common/byte_stream_if.sv
logic/eth_header_gen.sv
logic/byte_fifo.sv
logic/crc32_gmii.sv
packet_gen/frame_admit.sv
packet_gen/packet_gen.sv
logic/udp_tx_top.sv
tb/udp_tx_chk.sv
tb/udp_tx_tb.sv

// File: Makefile
# Verilator build and run of the UDP transmitter testbench

VERILATOR ?= verilator
TOP       ?= udp_tx_tb
FILELIST  ?= udp_tx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
